/* common/arm_params.svh */
// core widths and constants
// register file geometry, pc step and flag width
`ifndef ARM_PARAMS_SVH
`define ARM_PARAMS_SVH

// datapath
`define ARM_XLEN        32 // data and address width
`define ARM_REG_ADDR_W  4  // 16 architectural registers

// register 15 reads as instruction address + 8
`define ARM_PC_REG      15

`define ARM_INSTR_BYTES 4  // fetch step
`define ARM_FLAG_W      4  // n z c v

`endif

/* common/isaPkg.sv */
// instruction-set types for the core
// alu ops, condition codes, immediate formats, opcode classes, flags
`default_nettype none

package isaPkg;

    typedef enum logic [1:0] {
        ALU_ADD = 2'b00,
        ALU_SUB = 2'b01,
        ALU_AND = 2'b10,
        ALU_ORR = 2'b11
    } aluOp_t;

    // instr[31:28], any other code executes always
    typedef enum logic [3:0] {
        EQ = 4'b0000,
        NE = 4'b0001,
        GE = 4'b1010,
        LT = 4'b1011,
        GT = 4'b1100,
        LE = 4'b1101,
        AL = 4'b1110
    } cond_t;

    typedef enum logic [1:0] {
        IMM8  = 2'b00, // data processing, sign extended
        IMM12 = 2'b01, // ldr/str offset, zero extended
        BR24  = 2'b10  // branch word offset
    } immSrc_t;

    typedef enum logic [2:0] {
        DP_ADD, DP_SUB, DP_AND, DP_ORR,
        MEM_LDR, MEM_STR, BRANCH, NOP
    } instrClass_t;

    typedef struct packed {
        logic n;
        logic z;
        logic c; // kept, not read by any condition
        logic v;
    } flags_t;

endpackage

`default_nettype wire

/* common/pipePkg.sv */
// pipeline types
// decoded control word, stage registers, hazard controls, forwarding selects
`default_nettype none
`include "arm_params.svh"

package pipePkg;

    typedef struct packed {
        logic            regWrite;
        logic            memWrite;
        logic            memToReg;
        logic            aluSrc;      // immediate as operand b
        logic            branch;
        logic            flagWrite;   // subs
        isaPkg::aluOp_t  aluOp;
        isaPkg::immSrc_t immSrc;
        logic            regSrcPc;    // ra1 reads r15
        logic            regSrcStore; // ra2 reads rd, store data
    } decodeCtrl_t;

    // decode/execute register
    typedef struct packed {
        decodeCtrl_t                ctrl;
        logic [`ARM_XLEN-1:0]       rd1;
        logic [`ARM_XLEN-1:0]       rd2;
        logic [`ARM_XLEN-1:0]       extImm;
        logic [`ARM_XLEN-1:0]       pcPlus8;
        logic [`ARM_REG_ADDR_W-1:0] ra1;
        logic [`ARM_REG_ADDR_W-1:0] ra2;
        logic [`ARM_REG_ADDR_W-1:0] wa3;
        isaPkg::cond_t              cond;
    } idEx_t;

    typedef struct packed {
        logic                       regWrite; // already condition gated
        logic                       memToReg;
        logic                       memWrite;
        logic [`ARM_XLEN-1:0]       aluOut;   // also the data address
        logic [`ARM_XLEN-1:0]       writeData;
        logic [`ARM_REG_ADDR_W-1:0] wa3;
    } exMem_t;

    typedef struct packed {
        logic                       regWrite;
        logic                       memToReg;
        logic [`ARM_XLEN-1:0]       aluOut;
        logic [`ARM_XLEN-1:0]       readData;
        logic [`ARM_REG_ADDR_W-1:0] wa3;
    } memWb_t;

    typedef struct packed {
        logic stallF;
        logic stallD;
        logic flushD;
        logic flushE;
    } hazardCtrl_t;

    typedef enum logic [1:0] {
        NONE     = 2'b00,
        FROM_WB  = 2'b01,
        FROM_MEM = 2'b10
    } fwdSel_t;

endpackage

`default_nettype wire

/* source/armFetch.sv */
// program counter with next-pc select
// fetch/decode register with stall and flush
`default_nettype none
`include "arm_params.svh"

module armFetch (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic [`ARM_XLEN-1:0] instrF,
    input  wire pipePkg::hazardCtrl_t hazard,
    input  wire logic                 branchTaken,
    input  wire logic [`ARM_XLEN-1:0] branchTarget,
    output logic      [`ARM_XLEN-1:0] pcF,
    output logic      [`ARM_XLEN-1:0] instrD,
    output logic      [`ARM_XLEN-1:0] pcPlus8D  // value read through r15
);
    logic [`ARM_XLEN-1:0] pcPlus4F;

    assign pcPlus4F = pcF + `ARM_XLEN'(`ARM_INSTR_BYTES);

    always_ff @(posedge clk) begin
        if (rst) begin
            pcF <= '0;
        end else if (branchTaken) begin
            pcF <= branchTarget;  // resolved in execute
        end else if (!hazard.stallF) begin
            pcF <= pcPlus4F;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            instrD   <= '0;
            pcPlus8D <= '0;
        end else if (!hazard.stallD) begin  // stall wins over flush
            instrD   <= hazard.flushD ? '0 : instrF;
            pcPlus8D <= hazard.flushD ? '0 : pcPlus4F + `ARM_XLEN'(`ARM_INSTR_BYTES);
        end
    end

endmodule

`default_nettype wire

/* source/armControl.sv */
// instruction decoder
// forwarding selects, load-use and branch hazard controls
`default_nettype none
`include "arm_params.svh"

module armControl (
    input  wire logic                       clk,
    input  wire logic                       rst,
    input  wire logic [`ARM_XLEN-1:0]       instrD,
    input  wire logic [`ARM_REG_ADDR_W-1:0] ra1D,
    input  wire logic [`ARM_REG_ADDR_W-1:0] ra2D,
    input  wire logic [`ARM_REG_ADDR_W-1:0] wa3E,
    input  wire logic                       memToRegE, // load in execute
    input  wire pipePkg::exMem_t            exMem,
    input  wire logic [`ARM_REG_ADDR_W-1:0] wa3W,
    input  wire logic                       regWriteW,
    input  wire logic [`ARM_REG_ADDR_W-1:0] ra1E,
    input  wire logic [`ARM_REG_ADDR_W-1:0] ra2E,
    input  wire logic                       branchTaken,
    output pipePkg::decodeCtrl_t            ctrlD,
    output pipePkg::hazardCtrl_t            hazard,
    output pipePkg::fwdSel_t                fwdA,
    output pipePkg::fwdSel_t                fwdB
);
    import isaPkg::*;
    import pipePkg::*;

    instrClass_t instrClass;
    logic        validD;   // decode register holds a fetched instruction
    logic        ldrStall;

    // mem stage wins over wb, r15 is substituted in execute instead
    function automatic fwdSel_t fwdFor(input logic [`ARM_REG_ADDR_W-1:0] ra);
        if (ra == `ARM_REG_ADDR_W'(`ARM_PC_REG))
            return NONE;
        if (exMem.regWrite && ra == exMem.wa3)
            return FROM_MEM;
        if (regWriteW && ra == wa3W)
            return FROM_WB;
        return NONE;
    endfunction

    // tracks bubbles in the fetch/decode register, an all-zero word decodes as AND
    always_ff @(posedge clk) begin
        if (rst) begin
            validD <= 1'b0;
        end else if (!hazard.stallD) begin
            validD <= !hazard.flushD;
        end
    end

    // --------------------------------------------------
    // decode, opcode class from instr[27:20]
    always_comb begin
        instrClass = NOP;
        if (validD) begin
            casez (instrD[27:20])
                8'b00?_0100_0: instrClass = DP_ADD;  // reg or imm
                8'b00?_0010_?: instrClass = DP_SUB;  // bit 20 is subs
                8'b000_0000_0: instrClass = DP_AND;
                8'b000_1100_0: instrClass = DP_ORR;
                8'b010_1100_1: instrClass = MEM_LDR;
                8'b010_1100_0: instrClass = MEM_STR;
                8'b1010_????:  instrClass = BRANCH;
                default:       instrClass = NOP;
            endcase
        end
    end

    always_comb begin
        ctrlD = '0; // bubble, no writes
        case (instrClass)
            DP_ADD, DP_SUB: begin
                ctrlD.regWrite  = 1'b1;
                ctrlD.aluSrc    = instrD[25];
                ctrlD.aluOp     = (instrClass == DP_SUB) ? ALU_SUB : ALU_ADD;
                ctrlD.flagWrite = (instrClass == DP_SUB) && instrD[20];
            end
            DP_AND: begin
                ctrlD.regWrite = 1'b1;
                ctrlD.aluOp    = ALU_AND;
            end
            DP_ORR: begin
                ctrlD.regWrite = 1'b1;
                ctrlD.aluOp    = ALU_ORR;
            end
            MEM_LDR, MEM_STR: begin
                ctrlD.regWrite    = (instrClass == MEM_LDR);
                ctrlD.memToReg    = (instrClass == MEM_LDR);
                ctrlD.memWrite    = (instrClass == MEM_STR);
                ctrlD.regSrcStore = (instrClass == MEM_STR); // rd is store data
                ctrlD.aluSrc      = 1'b1;                    // base + offset
                ctrlD.immSrc      = IMM12;
            end
            BRANCH: begin
                ctrlD.branch   = 1'b1;
                ctrlD.aluSrc   = 1'b1;
                ctrlD.immSrc   = BR24;
                ctrlD.regSrcPc = 1'b1; // target = pc + 8 + offset
            end
            default: ;
        endcase
    end

    // --------------------------------------------------
    // hazards
    always_comb begin
        fwdA = fwdFor(ra1E);
        fwdB = fwdFor(ra2E);
    end

    assign ldrStall = memToRegE && (ra1D == wa3E || ra2D == wa3E) && validD;

    always_comb begin
        hazard.stallF = ldrStall || ctrlD.branch;  // branch holds pc one cycle
        hazard.stallD = ldrStall;
        hazard.flushD = ctrlD.branch || branchTaken;
        hazard.flushE = ldrStall || branchTaken;   // bubble into execute
    end

endmodule

`default_nettype wire

/* source/armDecode.sv */
// register file, 16 x 32, two async reads and one write per cycle
// read address select and immediate extension
`default_nettype none
`include "arm_params.svh"

module armDecode (
    input  wire logic                       clk,
    input  wire logic [`ARM_XLEN-1:0]       instrD,
    input  wire pipePkg::decodeCtrl_t       ctrlD,
    input  wire logic                       regWriteW,
    input  wire logic [`ARM_REG_ADDR_W-1:0] wa3W,
    input  wire logic [`ARM_XLEN-1:0]       resultW,
    output logic      [`ARM_REG_ADDR_W-1:0] ra1D,
    output logic      [`ARM_REG_ADDR_W-1:0] ra2D,
    output logic      [`ARM_XLEN-1:0]       rd1D,
    output logic      [`ARM_XLEN-1:0]       rd2D,
    output logic      [`ARM_XLEN-1:0]       extImmD
);
    import isaPkg::*;

    logic [`ARM_XLEN-1:0] regFile [2**`ARM_REG_ADDR_W];

    // rn, or r15 for a branch target
    assign ra1D = ctrlD.regSrcPc ? `ARM_REG_ADDR_W'(`ARM_PC_REG) : instrD[19:16];
    // rm, or rd for store data
    assign ra2D = ctrlD.regSrcStore ? instrD[15:12] : instrD[3:0];

    // written at the falling edge of writeback, so a decode read in that cycle
    // already sees the new value three instructions behind the writer
    always_ff @(negedge clk) begin
        if (regWriteW) begin
            regFile[wa3W] <= resultW;
        end
    end

    assign rd1D = regFile[ra1D];  // r15 entry is replaced in execute
    assign rd2D = regFile[ra2D];

    always_comb begin
        case (ctrlD.immSrc)
            IMM8:    extImmD = {{(`ARM_XLEN-8){instrD[7]}}, instrD[7:0]};
            IMM12:   extImmD = {{(`ARM_XLEN-12){1'b0}}, instrD[11:0]};
            default: extImmD = {{(`ARM_XLEN-26){instrD[23]}}, instrD[23:0], 2'b00}; // words
        endcase
    end

endmodule

`default_nettype wire

/* execute/armAlu.sv */
// alu with add, subtract, and, or
// nzcv flags, carry and overflow from add/sub only
`default_nettype none
`include "arm_params.svh"

module armAlu (
    input  wire logic [`ARM_XLEN-1:0] a,
    input  wire logic [`ARM_XLEN-1:0] b,
    input  wire isaPkg::aluOp_t       op,
    output logic      [`ARM_XLEN-1:0] result,
    output isaPkg::flags_t            flags
);
    import isaPkg::*;

    logic [`ARM_XLEN-1:0] bOp;    // b, inverted for subtract
    logic [`ARM_XLEN:0]   sum;    // carry out in the msb
    logic                 arith;

    assign arith = (op == ALU_ADD) || (op == ALU_SUB);
    assign bOp   = (op == ALU_SUB) ? ~b : b;
    assign sum   = {1'b0, a} + {1'b0, bOp} + {{`ARM_XLEN{1'b0}}, op == ALU_SUB}; // a + ~b + 1

    always_comb begin
        case (op)
            ALU_AND: result = a & b;
            ALU_ORR: result = a | b;
            default: result = sum[`ARM_XLEN-1:0];
        endcase
    end

    // overflow when operands agree in sign and the result does not
    assign flags = '{n: result[`ARM_XLEN-1],
                     z: result == '0,
                     c: arith && sum[`ARM_XLEN],
                     v: arith && (a[`ARM_XLEN-1] == bOp[`ARM_XLEN-1])
                              && (sum[`ARM_XLEN-1] != a[`ARM_XLEN-1])};

endmodule

`default_nettype wire

/* execute/armExecute.sv */
// decode/execute register, operand forwarding and alu
// condition check, nzcv flag register, execute/memory register
`default_nettype none
`include "arm_params.svh"

module armExecute (
    input  wire logic                       clk,
    input  wire logic                       rst,
    input  wire pipePkg::decodeCtrl_t       ctrlD,
    input  wire logic [`ARM_XLEN-1:0]       instrD,
    input  wire logic [`ARM_REG_ADDR_W-1:0] ra1D,
    input  wire logic [`ARM_REG_ADDR_W-1:0] ra2D,
    input  wire logic [`ARM_XLEN-1:0]       rd1D,
    input  wire logic [`ARM_XLEN-1:0]       rd2D,
    input  wire logic [`ARM_XLEN-1:0]       extImmD,
    input  wire logic [`ARM_XLEN-1:0]       pcPlus8D,
    input  wire pipePkg::hazardCtrl_t       hazard,
    input  wire pipePkg::fwdSel_t           fwdA,
    input  wire pipePkg::fwdSel_t           fwdB,
    input  wire logic [`ARM_XLEN-1:0]       resultW,
    output pipePkg::exMem_t                 exMem,
    output logic      [`ARM_REG_ADDR_W-1:0] ra1E,
    output logic      [`ARM_REG_ADDR_W-1:0] ra2E,
    output logic      [`ARM_REG_ADDR_W-1:0] wa3E,
    output logic                            memToRegE,
    output logic                            branchTaken,
    output logic      [`ARM_XLEN-1:0]       branchTarget
);
    import isaPkg::*;
    import pipePkg::*;

    idEx_t                idEx;
    flags_t               flagsQ;     // changes only on a passing subs
    flags_t               aluFlags;
    logic [`ARM_XLEN-1:0] srcA, srcB, writeDataE, aluResult;
    logic                 condEx;

    // r15 reads as pc + 8, then forwarding overrides the register value
    function automatic logic [`ARM_XLEN-1:0] pickOperand(
        input fwdSel_t                    sel,
        input logic [`ARM_REG_ADDR_W-1:0] ra,
        input logic [`ARM_XLEN-1:0]       rd
    );
        case (sel)
            FROM_MEM: return exMem.aluOut;
            FROM_WB:  return resultW;
            default:  return (ra == `ARM_REG_ADDR_W'(`ARM_PC_REG)) ? idEx.pcPlus8 : rd;
        endcase
    endfunction

    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst || hazard.flushE) begin
            idEx <= '0;  // bubble
        end else begin
            idEx <= '{ctrl: ctrlD, rd1: rd1D, rd2: rd2D, extImm: extImmD,
                      pcPlus8: pcPlus8D, ra1: ra1D, ra2: ra2D,
                      wa3: instrD[15:12], cond: cond_t'(instrD[31:28])};
        end
    end

    always_comb begin
        srcA       = pickOperand(fwdA, idEx.ra1, idEx.rd1);
        writeDataE = pickOperand(fwdB, idEx.ra2, idEx.rd2);  // also store data
    end

    assign srcB = idEx.ctrl.aluSrc ? idEx.extImm : writeDataE;

    armAlu uAlu (
        .a      (srcA),
        .b      (srcB),
        .op     (idEx.ctrl.aluOp),
        .result (aluResult),
        .flags  (aluFlags)
    );

    // --------------------------------------------------
    // condition on n and z only
    always_comb begin
        case (idEx.cond)
            EQ:      condEx = flagsQ.z;
            NE:      condEx = !flagsQ.z;
            GE:      condEx = flagsQ.z || !flagsQ.n;
            GT:      condEx = !flagsQ.n;
            LE:      condEx = flagsQ.z || flagsQ.n;
            LT:      condEx = flagsQ.n;
            default: condEx = 1'b1;  // AL and unsupported codes
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            flagsQ <= flags_t'({`ARM_FLAG_W{1'b0}});
        end else if (idEx.ctrl.flagWrite && condEx) begin
            flagsQ <= aluFlags;
        end
    end

    assign branchTaken  = idEx.ctrl.branch && condEx;
    assign branchTarget = aluResult;  // pc + 8 + offset

    // failed condition cancels both writes
    always_ff @(posedge clk) begin
        if (rst) begin
            exMem <= '0;
        end else begin
            exMem <= '{regWrite: idEx.ctrl.regWrite && condEx,
                       memToReg: idEx.ctrl.memToReg,
                       memWrite: idEx.ctrl.memWrite && condEx,
                       aluOut: aluResult, writeData: writeDataE, wa3: idEx.wa3};
        end
    end

    // hazard view for the control unit
    assign ra1E      = idEx.ra1;
    assign ra2E      = idEx.ra2;
    assign wa3E      = idEx.wa3;
    assign memToRegE = idEx.ctrl.memToReg;

endmodule

`default_nettype wire

/* source/armWriteback.sv */
// memory/writeback register
// result select between loaded word and alu result
`default_nettype none
`include "arm_params.svh"

module armWriteback (
    input  wire logic                       clk,
    input  wire logic                       rst,
    input  wire pipePkg::exMem_t            exMem,
    input  wire logic [`ARM_XLEN-1:0]       readDataM,
    output logic      [`ARM_XLEN-1:0]       resultW,
    output logic      [`ARM_REG_ADDR_W-1:0] wa3W,
    output logic                            regWriteW
);
    import pipePkg::*;

    memWb_t memWb;

    always_ff @(posedge clk) begin
        if (rst) begin
            memWb <= '0;
        end else begin
            memWb <= '{regWrite: exMem.regWrite, memToReg: exMem.memToReg,
                       aluOut: exMem.aluOut, readData: readDataM, wa3: exMem.wa3};
        end
    end

    assign resultW   = memWb.memToReg ? memWb.readData : memWb.aluOut;  // ldr or alu
    assign wa3W      = memWb.wa3;
    assign regWriteW = memWb.regWrite;

endmodule

`default_nettype wire

/* source/armCore.sv */
// five-stage pipelined core for a small arm subset
// fetch, decode, execute and writeback stages around the control unit
`default_nettype none
`include "arm_params.svh"

module armCore (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic [`ARM_XLEN-1:0] instrF,    // instruction memory, same cycle
    input  wire logic [`ARM_XLEN-1:0] readDataM, // data memory, same cycle
    output logic      [`ARM_XLEN-1:0] pcF,
    output logic      [`ARM_XLEN-1:0] aluOutM,   // data address
    output logic      [`ARM_XLEN-1:0] writeDataM,
    output logic                      memWriteM
);
    import pipePkg::*;

    // decode side
    logic [`ARM_XLEN-1:0]       instrD, pcPlus8D;
    logic [`ARM_XLEN-1:0]       rd1D, rd2D, extImmD;
    logic [`ARM_REG_ADDR_W-1:0] ra1D, ra2D;
    decodeCtrl_t                ctrlD;
    hazardCtrl_t                hazard;
    fwdSel_t                    fwdA, fwdB;

    // execute and memory side
    exMem_t                     exMem;
    logic [`ARM_REG_ADDR_W-1:0] ra1E, ra2E, wa3E;
    logic                       memToRegE;
    logic                       branchTaken;
    logic [`ARM_XLEN-1:0]       branchTarget;

    // writeback side
    logic [`ARM_XLEN-1:0]       resultW;
    logic [`ARM_REG_ADDR_W-1:0] wa3W;
    logic                       regWriteW;

    // --------------------------------------------------
    armFetch uFetch (
        .clk, .rst, .instrF, .hazard, .branchTaken, .branchTarget,
        .pcF, .instrD, .pcPlus8D
    );

    armControl uControl (
        .clk, .rst, .instrD, .ra1D, .ra2D, .wa3E, .memToRegE, .exMem,
        .wa3W, .regWriteW, .ra1E, .ra2E, .branchTaken,
        .ctrlD, .hazard, .fwdA, .fwdB
    );

    armDecode uDecode (
        .clk, .instrD, .ctrlD, .regWriteW, .wa3W, .resultW,
        .ra1D, .ra2D, .rd1D, .rd2D, .extImmD
    );

    armExecute uExecute (
        .clk, .rst, .ctrlD, .instrD, .ra1D, .ra2D, .rd1D, .rd2D, .extImmD,
        .pcPlus8D, .hazard, .fwdA, .fwdB, .resultW,
        .exMem, .ra1E, .ra2E, .wa3E, .memToRegE, .branchTaken, .branchTarget
    );

    armWriteback uWriteback (
        .clk, .rst, .exMem, .readDataM, .resultW, .wa3W, .regWriteW
    );

    // memory stage is just the data memory port
    assign aluOutM    = exMem.aluOut;
    assign writeDataM = exMem.writeData;
    assign memWriteM  = exMem.memWrite;

endmodule

`default_nettype wire

/* dv/armCore_sva.sv */
// concurrent checks bound into the core
// reset state, pc step, load-use stall, branch target, store timing, marker
`default_nettype none
`include "arm_params.svh"

module armCoreSva #(
    parameter logic [`ARM_XLEN-1:0] markerAddr = 32'h0000_00F0
) (
    input wire logic                 clk,
    input wire logic                 rst,
    input wire logic [`ARM_XLEN-1:0] pcF,
    input wire logic [`ARM_XLEN-1:0] instrF,
    input wire logic                 memWriteM,
    input wire logic [`ARM_XLEN-1:0] aluOutM,
    input wire logic                 branchTaken
);
    timeunit 1ns;
    timeprecision 100ps;

    int failCount = 0;

    // b or ldr on the fetch bus, either one may hold or redirect the pc
    function automatic logic holdsPc(input logic [`ARM_XLEN-1:0] instr);
        return instr[27:24] == 4'b1010 || instr[27:20] == 8'h59;
    endfunction

    // --------------------------------------------------
    resetState: assert property (@(posedge clk) rst |=> (pcF == '0 && !memWriteM))
        else begin failCount++; $error("pc or memWrite not cleared by reset"); end

    // nothing fetched in the last two cycles can stall or branch
    pcStep: assert property (@(posedge clk) disable iff (rst)
        (!holdsPc($past(instrF)) && !holdsPc($past(instrF, 2)))
            |=> pcF == $past(pcF) + `ARM_XLEN'(4))
        else begin failCount++; $error("pc did not advance by one word"); end

    // ldr then a reader of its rd, pc holds one cycle and then steps again
    loadUseOnce: assert property (@(posedge clk) disable iff (rst)
        ($past(instrF[27:20], 4) == 8'h59
            && $past(instrF[19:16], 3) == $past(instrF[15:12], 4))
            |-> ($past(pcF) == $past(pcF, 2) && pcF == $past(pcF) + `ARM_XLEN'(4)))
        else begin failCount++; $error("load-use stall length wrong"); end

    // fetched two cycles before it resolves, target is pc + 8 + offset words
    branchJump: assert property (@(posedge clk) disable iff (rst)
        branchTaken |=> pcF == $past(pcF, 3) + `ARM_XLEN'(8)
            + (`ARM_XLEN'($signed($past(instrF[23:0], 3))) << 2))
        else begin failCount++; $error("taken branch missed its target"); end

    // str opcode seen on the fetch bus three cycles earlier
    storeLatency: assert property (@(posedge clk) disable iff (rst)
        memWriteM |-> $past(instrF[27:20], 3) == 8'h58)
        else begin failCount++; $error("store reached memory at the wrong cycle"); end

    noMarker: assert property (@(posedge clk) disable iff (rst)
        memWriteM |-> aluOutM != markerAddr)
        else begin failCount++; $error("write to the marker address"); end

endmodule

`default_nettype wire

/* dv/tb_armCore.sv */
// testbench for the pipelined core
// instruction rom, data ram, directed program, store monitor and watchdog
`default_nettype none
`include "arm_params.svh"

module tb_armCore;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int progLen = 22;    // words of the directed program
    localparam int memWords = 64;

    logic                 clk;
    logic                 rst;
    logic [`ARM_XLEN-1:0] instrF, readDataM, pcF, aluOutM, writeDataM;
    logic                 memWriteM;

    logic [`ARM_XLEN-1:0] rom [memWords];
    logic [`ARM_XLEN-1:0] ram [memWords];
    logic [`ARM_XLEN-1:0] ramInit [memWords];  // seeded copy for expected values
    logic [`ARM_XLEN-1:0] expAddr [$];
    logic [`ARM_XLEN-1:0] expData [$];
    int                   errCount;

    armCore DUT (
        .clk, .rst, .instrF, .readDataM, .pcF, .aluOutM, .writeDataM, .memWriteM
    );

    bind armCore armCoreSva #(.markerAddr(32'h0000_00F0)) uSva (
        .clk, .rst, .pcF, .instrF, .memWriteM, .aluOutM, .branchTaken
    );

    always #50 clk = ~clk;

    // both memories answer in the same cycle
    assign instrF    = rom[pcF[7:2]];
    assign readDataM = ram[aluOutM[7:2]];

    always @(posedge clk) begin
        if (memWriteM)
            ram[aluOutM[7:2]] <= writeDataM;
    end

    // --------------------------------------------------
    // store monitor, outputs are stable at the falling edge
    always @(negedge clk) begin
        if (!rst && memWriteM) begin
            if (expAddr.size() == 0) begin
                $display("unexpected store of %h to address %h at %0t", writeDataM, aluOutM,
                         $time);
                errCount++;
            end else begin
                if (aluOutM !== expAddr[0]) begin
                    $display("ERR t=%0t aluOutM expected %h got %h", $time, expAddr[0], aluOutM);
                    errCount++;
                end
                if (writeDataM !== expData[0]) begin
                    $display("ERR t=%0t writeDataM expected %h got %h", $time, expData[0],
                             writeDataM);
                    errCount++;
                end
                void'(expAddr.pop_front());
                void'(expData.pop_front());
            end
        end
    end

    task automatic expectStore(input logic [31:0] addr, input logic [31:0] data);
        expAddr.push_back(addr);
        expData.push_back(data);
    endtask

    // --------------------------------------------------
    task automatic loadProgram();
        foreach (rom[i]) rom[i] = '0;
        rom[0]  = 32'hE04F_000F; // sub  r0, r15, r15  -> 0
        rom[1]  = 32'hE280_1005; // add  r1, r0, #5
        rom[2]  = 32'hE081_2001; // add  r2, r1, r1, forwarded
        rom[3]  = 32'hE580_2040; // str  r2, [r0, #0x40]
        rom[4]  = 32'hE590_3020; // ldr  r3, [r0, #0x20]
        rom[5]  = 32'hE283_4007; // add  r4, r3, #7, load-use
        rom[6]  = 32'hE580_4044; // str  r4, [r0, #0x44]
        rom[7]  = 32'hE051_5001; // subs r5, r1, r1  z set
        rom[8]  = 32'h0580_2048; // streq
        rom[9]  = 32'h1580_204C; // strne, cancelled
        rom[10] = 32'hE052_5001; // subs r5, r2, r1  z clear
        rom[11] = 32'h0580_1050; // streq, cancelled
        rom[12] = 32'h1580_1054; // strne
        rom[13] = 32'hEA00_0000; // b over the marker store
        rom[14] = 32'hE580_20F0; // str to marker, never executes
        rom[15] = 32'h0A00_0000; // beq, not taken
        rom[16] = 32'hE580_1058; // str r1
        rom[17] = 32'hE004_6002; // and  r6, r4, r2
        rom[18] = 32'hE184_7001; // orr  r7, r4, r1
        rom[19] = 32'hE580_605C;
        rom[20] = 32'hE580_7060;
        rom[21] = 32'hEAFF_FFFE; // b . (end of program)
    endtask

    initial begin
        logic [31:0] r4;
        clk      = 1'b0;
        rst      = 1'b1;
        errCount = 0;
        void'($urandom(10970));
        foreach (ram[i]) begin
            ram[i]     = $urandom;
            ramInit[i] = ram[i];
        end
        loadProgram();
        r4 = ramInit[8] + 32'd7;
        expectStore(32'h40, 32'd10);
        expectStore(32'h44, r4);
        expectStore(32'h48, 32'd10);
        expectStore(32'h54, 32'd5);
        expectStore(32'h58, 32'd5);
        expectStore(32'h5C, r4 & 32'd10);
        expectStore(32'h60, r4 | 32'd5);

        repeat (16) @(posedge clk);
        #1 rst = 1'b0;

        wait (expAddr.size() == 0);
        repeat (6) @(posedge clk);  // catch stray writes after the last store

        $display("value errors: %0d, assertion failures: %0d", errCount, DUT.uSva.failCount);
        if (errCount == 0 && DUT.uSva.failCount == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // watchdog, sized from the program length
    initial begin
        @(negedge rst);
        #((progLen + 40) * 100);
        $display("timeout: %0d expected stores never appeared", expAddr.size());
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
+incdir+common
common/isaPkg.sv
common/pipePkg.sv
source/armFetch.sv
source/armControl.sv
source/armDecode.sv
execute/armAlu.sv
execute/armExecute.sv
source/armWriteback.sv
source/armCore.sv
dv/armCore_sva.sv
dv/tb_armCore.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -f flist.f --top-module tb_armCore \
    --Mdir obj_dir -o simv > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/simv +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log

grep -q "TEST RESULT: FAIL" sim.log && { echo "simulation failed"; exit 1; }
grep -q "TEST RESULT: PASS" sim.log || { echo "no result line in log"; exit 1; }
exit 0
